//--- src.f
source/valu_pkg.sv
source/valu_decode.sv
source/valu_add_min_max.sv
source/valu_logic.sv
source/valu_resp_align.sv
source/valu_top.sv
test/valu_properties.sv
test/valu_tb.sv

//--- Bender.yml
package:
  name: valu

sources:
  - files:
      - source/valu_pkg.sv
      - source/valu_decode.sv
      - source/valu_add_min_max.sv
      - source/valu_logic.sv
      - source/valu_resp_align.sv
      - source/valu_top.sv
  - target: test
    files:
      - test/valu_properties.sv
      - test/valu_tb.sv

//--- test/valu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module valu_tb;

    localparam int N_RAND       = 8;
    localparam int ARITH_REQS   = 4 * 3 * (N_RAND + 2);
    localparam int MINMAX_REQS  = 4 * 4 * (N_RAND + 2);
    localparam int LOGIC_REQS   = 4 * N_RAND;
    localparam int STREAM_REQS  = 64;
    localparam int UNREC_REQS   = 24;
    localparam int DRAIN        = 6;
    localparam int TOTAL_CYCLES = 2 + ARITH_REQS + MINMAX_REQS + LOGIC_REQS + STREAM_REQS
                                  + UNREC_REQS + 5 * DRAIN;
    localparam int MARGIN       = 50;

    typedef struct packed {
        logic                valid;
        valu_pkg::data_t     data;
        valu_pkg::sideband_t sb;
    } expect_t;

    logic               clk;
    logic               rst;
    logic               req_valid;
    valu_pkg::func_id_t req_func_id;
    logic               req_mask;
    valu_pkg::data_t    req_data0;
    valu_pkg::data_t    req_data1;
    valu_pkg::sew_t     req_sew;
    valu_pkg::vl_t      req_vl;
    valu_pkg::off_t     req_off;
    valu_pkg::addr_t    req_addr;
    valu_pkg::be_t      req_be;
    logic               req_start;
    logic               req_end;
    logic               resp_valid;
    logic               resp_start;
    logic               resp_end;
    valu_pkg::data_t    resp_data;
    valu_pkg::sew_t     resp_sew;
    valu_pkg::vl_t      resp_vl;
    valu_pkg::off_t     resp_off;
    valu_pkg::addr_t    resp_addr;
    valu_pkg::be_t      resp_be;

    int      value_errors = 0;
    int      valid_errors = 0;
    string   cur_test = "reset";
    expect_t exp_q [$];
    string   name_q [$];

    valu_top uut (.*);

    always #4 clk = ~clk;

    function automatic valu_pkg::data_t rand_data();
        return {$urandom, $urandom};
    endfunction

    // copy a small value into every lane
    function automatic valu_pkg::data_t lane_fill(input valu_pkg::data_t v,
            input valu_pkg::sew_t sew);
        int              lw;
        valu_pkg::data_t r;
        lw = 8 << sew;
        r = '0;
        for (int l = 0; l < 64 / lw; l++) begin
            r = r | (v << (l * lw));
        end
        return r;
    endfunction

    // lane by lane reference result and whether a response is due
    function automatic valu_pkg::data_t model(input valu_pkg::func_id_t f, input logic mask,
            input valu_pkg::data_t d0, input valu_pkg::data_t d1, input valu_pkg::sew_t sew,
            output logic recognized);
        int          lw;
        logic [63:0] lmask;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] res;
        logic        lt_u;
        logic        lt_s;
        lw = 8 << sew;
        lmask = (lw == 64) ? '1 : ((64'd1 << lw) - 1);
        res = '0;
        recognized = 1'b1;
        for (int l = 0; l < 64 / lw; l++) begin
            a = (d1 >> (l * lw)) & lmask;
            b = (d0 >> (l * lw)) & lmask;
            lt_u = a < b;
            lt_s = (a[lw-1] != b[lw-1]) ? a[lw-1] : lt_u;  // sign bits differ
            case (f)
                valu_pkg::FUNC_ADD:  r = a + b;
                valu_pkg::FUNC_SUB:  r = a - b;
                valu_pkg::FUNC_RSUB: r = b - a;
                valu_pkg::FUNC_MINU: r = lt_u ? a : b;
                valu_pkg::FUNC_MIN:  r = lt_s ? a : b;
                valu_pkg::FUNC_MAXU: r = lt_u ? b : a;
                valu_pkg::FUNC_MAX:  r = lt_s ? b : a;
                valu_pkg::FUNC_AND:  r = a & b;
                valu_pkg::FUNC_OR:   r = a | b;
                valu_pkg::FUNC_XOR:  r = a ^ b;
                valu_pkg::FUNC_MOVE: begin
                    r = b;
                    recognized = mask;
                end
                default: begin
                    r = '0;
                    recognized = 1'b0;
                end
            endcase
            res = res | ((r & lmask) << (l * lw));
        end
        return recognized ? res : '0;
    endfunction

    task automatic check(input string test_name, input string field,
            input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, field, expected, actual);
            value_errors++;
        end
    endtask

    // inputs seen here are the ones the next rising edge samples
    always @(negedge clk) begin : monitor
        expect_t e;
        expect_t cur;
        string   nm;
        logic    rec;
        if (!rst) begin
            if (exp_q.size() == 3) begin
                e = exp_q.pop_front();
                nm = name_q.pop_front();
                if (resp_valid !== e.valid) begin
                    if (e.valid)
                        $display("%s: resp_valid missing 3 cycles after a request", nm);
                    else
                        $display("%s: resp_valid high with no recognized request", nm);
                    valid_errors++;
                end else if (e.valid) begin
                    check(nm, "data", e.data, resp_data);
                end
                check(nm, "start", e.sb.start_flag, resp_start);
                check(nm, "end", e.sb.end_flag, resp_end);
                check(nm, "vl", e.sb.vl, resp_vl);
                check(nm, "sew", e.sb.sew, resp_sew);
                check(nm, "off", e.sb.off, resp_off);
                check(nm, "addr", e.sb.addr, resp_addr);
                check(nm, "be", e.sb.be, resp_be);
            end
            cur.data = model(req_func_id, req_mask, req_data0, req_data1, req_sew, rec);
            cur.valid = req_valid & rec;
            cur.sb = '{start_flag: req_start & req_valid, end_flag: req_end & req_valid,
                       vl: req_vl, sew: req_sew, off: req_off, addr: req_addr, be: req_be};
            exp_q.push_back(cur);
            name_q.push_back(cur_test);
        end
    end

    task automatic send(input logic valid, input valu_pkg::func_id_t f, input logic mask,
            input valu_pkg::data_t d0, input valu_pkg::data_t d1, input valu_pkg::sew_t sew);
        @(posedge clk);
        req_valid   <= valid;
        req_func_id <= f;
        req_mask    <= mask;
        req_data0   <= d0;
        req_data1   <= d1;
        req_sew     <= sew;
        req_vl      <= valu_pkg::vl_t'($urandom);   // fresh sideband every request
        req_off     <= valu_pkg::off_t'($urandom);
        req_addr    <= valu_pkg::addr_t'($urandom);
        req_be      <= valu_pkg::be_t'($urandom);
        req_start   <= 1'($urandom);
        req_end     <= 1'($urandom);
    endtask

    task automatic drain();
        repeat (DRAIN) send(1'b0, '0, 1'b0, '0, '0, valu_pkg::SEW_8);
    endtask

    task automatic test_add_sub();
        valu_pkg::sew_t     sew;
        valu_pkg::func_id_t ops [3] = '{valu_pkg::FUNC_ADD, valu_pkg::FUNC_SUB,
                                        valu_pkg::FUNC_RSUB};
        cur_test = "add_sub";
        for (int s = 0; s < 4; s++) begin
            sew = valu_pkg::sew_t'(s);
            for (int o = 0; o < 3; o++) begin
                send(1'b1, ops[o], 1'b0, lane_fill(64'd1, sew), '1, sew);  // wraps inside lanes
                send(1'b1, ops[o], 1'b0, lane_fill(64'd1, sew), '0, sew);
                repeat (N_RAND) send(1'b1, ops[o], 1'b0, rand_data(), rand_data(), sew);
            end
        end
        drain();
    endtask

    task automatic test_min_max();
        valu_pkg::sew_t     sew;
        valu_pkg::data_t    msb;
        valu_pkg::func_id_t ops [4] = '{valu_pkg::FUNC_MINU, valu_pkg::FUNC_MIN,
                                        valu_pkg::FUNC_MAXU, valu_pkg::FUNC_MAX};
        cur_test = "min_max";
        for (int s = 0; s < 4; s++) begin
            sew = valu_pkg::sew_t'(s);
            msb = lane_fill(64'd1 << ((8 << s) - 1), sew);  // negative signed, large unsigned
            for (int o = 0; o < 4; o++) begin
                send(1'b1, ops[o], 1'b0, lane_fill(64'd1, sew), msb, sew);
                send(1'b1, ops[o], 1'b0, msb, lane_fill(64'd1, sew), sew);
                repeat (N_RAND) send(1'b1, ops[o], 1'b0, rand_data(), rand_data(), sew);
            end
        end
        drain();
    endtask

    task automatic test_logic_move();
        valu_pkg::func_id_t ops [4] = '{valu_pkg::FUNC_AND, valu_pkg::FUNC_OR,
                                        valu_pkg::FUNC_XOR, valu_pkg::FUNC_MOVE};
        cur_test = "logic_move";
        for (int o = 0; o < 4; o++) begin
            repeat (N_RAND) send(1'b1, ops[o], 1'b1, rand_data(), rand_data(),
                                 valu_pkg::sew_t'($urandom));
        end
        drain();
    endtask

    task automatic test_stream();
        valu_pkg::func_id_t codes [11] = '{valu_pkg::FUNC_ADD, valu_pkg::FUNC_SUB,
            valu_pkg::FUNC_RSUB, valu_pkg::FUNC_MINU, valu_pkg::FUNC_MIN, valu_pkg::FUNC_MAXU,
            valu_pkg::FUNC_MAX, valu_pkg::FUNC_AND, valu_pkg::FUNC_OR, valu_pkg::FUNC_XOR,
            valu_pkg::FUNC_MOVE};
        cur_test = "stream";
        repeat (STREAM_REQS) begin
            send(1'b1, codes[$urandom % 11], 1'b1, rand_data(), rand_data(),
                 valu_pkg::sew_t'($urandom));
        end
        drain();
    endtask

    task automatic test_unrecognized();
        valu_pkg::func_id_t f;
        logic               rec;
        cur_test = "unrecognized";
        repeat (8) send(1'b1, valu_pkg::FUNC_MOVE, 1'b0, rand_data(), rand_data(),
                        valu_pkg::sew_t'($urandom));
        repeat (8) begin
            do begin
                f = valu_pkg::func_id_t'($urandom);
                void'(model(f, 1'b1, '0, '0, valu_pkg::SEW_8, rec));
            end while (rec);
            send(1'b1, f, 1'($urandom), rand_data(), rand_data(), valu_pkg::sew_t'($urandom));
        end
        // known code without req_valid so start and end are gated
        repeat (8) send(1'b0, valu_pkg::FUNC_ADD, 1'b1, rand_data(), rand_data(),
                        valu_pkg::sew_t'($urandom));
        drain();
    endtask

    initial begin
        int seed;
        seed = $urandom(79);
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_func_id = '0;
        req_mask = 1'b0;
        req_data0 = '0;
        req_data1 = '0;
        req_sew = valu_pkg::SEW_8;
        req_vl = '0;
        req_off = '0;
        req_addr = '0;
        req_be = '0;
        req_start = 1'b0;
        req_end = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_add_sub();
        test_min_max();
        test_logic_move();
        test_stream();
        test_unrecognized();
        $display("errors: %0d value mismatches, %0d resp_valid errors",
                 value_errors, valid_errors);
        if (value_errors + valid_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + MARGIN) * 8);
        $display("timeout: run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/valu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module valu_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic req_valid,
    input wire logic req_start,
    input wire logic add_en,
    input wire logic logic_en,
    input wire logic resp_valid,
    input wire logic resp_start
);

    logic accepted;

    assign accepted = add_en | logic_en;  // decode enables include req_valid

    a_latency: assert property (@(posedge clk) disable iff (rst)
        accepted |-> ##3 resp_valid)
        else $error("recognized request without resp_valid 3 cycles later");

    a_no_stray_valid: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(accepted, 3))
        else $error("resp_valid without a recognized request 3 cycles earlier");

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !resp_valid [*3])
        else $error("resp_valid high within 3 cycles of reset release");

    a_start_source: assert property (@(posedge clk) disable iff (rst)
        resp_start |-> $past(req_start & req_valid, 3))
        else $error("resp_start without a gated start 3 cycles earlier");

endmodule

bind valu_top valu_properties props (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_start  (req_start),
    .add_en     (add_ctrl.en),
    .logic_en   (logic_ctrl.en),
    .resp_valid (resp_valid),
    .resp_start (resp_start)
);

`default_nettype wire

//--- source/valu_top.sv
`timescale 1ns/1ns
`default_nettype none

module valu_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    input  wire valu_pkg::func_id_t     req_func_id,
    input  wire logic                   req_mask,
    input  wire valu_pkg::data_t        req_data0,
    input  wire valu_pkg::data_t        req_data1,   // vs2
    input  wire valu_pkg::sew_t         req_sew,
    input  wire valu_pkg::vl_t          req_vl,
    input  wire valu_pkg::off_t         req_off,
    input  wire valu_pkg::addr_t        req_addr,
    input  wire valu_pkg::be_t          req_be,
    input  wire logic                   req_start,
    input  wire logic                   req_end,
    output logic                        resp_valid,
    output logic                        resp_start,
    output logic                        resp_end,
    output valu_pkg::data_t             resp_data,
    output valu_pkg::sew_t              resp_sew,
    output valu_pkg::vl_t               resp_vl,
    output valu_pkg::off_t              resp_off,
    output valu_pkg::addr_t             resp_addr,
    output valu_pkg::be_t               resp_be
);

    valu_pkg::add_ctrl_t    add_ctrl;
    valu_pkg::logic_ctrl_t  logic_ctrl;
    valu_pkg::unit_result_t add_result;
    valu_pkg::unit_result_t logic_result;
    valu_pkg::sideband_t    sideband;

    // start and end only count with a valid request
    assign sideband = '{
        start_flag: req_start & req_valid,
        end_flag:   req_end & req_valid,
        vl:         req_vl,
        sew:        req_sew,
        off:        req_off,
        addr:       req_addr,
        be:         req_be
    };

    valu_decode u_decode (
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_mask    (req_mask),
        .add_ctrl    (add_ctrl),
        .logic_ctrl  (logic_ctrl)
    );

    valu_add_min_max u_add (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (add_ctrl),
        .data0  (req_data0),
        .data1  (req_data1),
        .sew    (req_sew),
        .result (add_result)
    );

    valu_logic u_logic (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (logic_ctrl),
        .data0  (req_data0),
        .data1  (req_data1),
        .result (logic_result)
    );

    valu_resp_align u_resp (
        .clk          (clk),
        .rst          (rst),
        .sideband     (sideband),
        .add_result   (add_result),
        .logic_result (logic_result),
        .resp_valid   (resp_valid),
        .resp_start   (resp_start),
        .resp_end     (resp_end),
        .resp_data    (resp_data),
        .resp_sew     (resp_sew),
        .resp_vl      (resp_vl),
        .resp_off     (resp_off),
        .resp_addr    (resp_addr),
        .resp_be      (resp_be)
    );

endmodule

`default_nettype wire

//--- source/valu_resp_align.sv
`timescale 1ns/1ns
`default_nettype none

module valu_resp_align (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire valu_pkg::sideband_t    sideband,
    input  wire valu_pkg::unit_result_t add_result,
    input  wire valu_pkg::unit_result_t logic_result,
    output logic                        resp_valid,
    output logic                        resp_start,
    output logic                        resp_end,
    output valu_pkg::data_t             resp_data,
    output valu_pkg::sew_t              resp_sew,
    output valu_pkg::vl_t               resp_vl,
    output valu_pkg::off_t              resp_off,
    output valu_pkg::addr_t             resp_addr,
    output valu_pkg::be_t               resp_be
);

    valu_pkg::sideband_t sb_pipe [2];   // matches the two unit stages

    always_ff @(posedge clk) begin
        if (rst) begin
            sb_pipe[0] <= '0;
            sb_pipe[1] <= '0;
        end else begin
            sb_pipe[0] <= sideband;
            sb_pipe[1] <= sb_pipe[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
            resp_data  <= '0;
            resp_sew   <= valu_pkg::SEW_8;
            resp_vl    <= '0;
            resp_off   <= '0;
            resp_addr  <= '0;
            resp_be    <= '0;
        end else begin
            // idle units drive zero data
            resp_valid <= add_result.valid | logic_result.valid;
            resp_data  <= add_result.data | logic_result.data;
            resp_start <= sb_pipe[1].start_flag;
            resp_end   <= sb_pipe[1].end_flag;
            resp_sew   <= sb_pipe[1].sew;
            resp_vl    <= sb_pipe[1].vl;
            resp_off   <= sb_pipe[1].off;
            resp_addr  <= sb_pipe[1].addr;
            resp_be    <= sb_pipe[1].be;
        end
    end

endmodule

`default_nettype wire

//--- source/valu_logic.sv
`timescale 1ns/1ns
`default_nettype none

module valu_logic (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire valu_pkg::logic_ctrl_t  ctrl,
    input  wire valu_pkg::data_t        data0,
    input  wire valu_pkg::data_t        data1,
    output valu_pkg::unit_result_t      result
);

    valu_pkg::data_t opnd1;
    logic [1:0]      op;
    valu_pkg::data_t bitwise;

    logic            s1_valid;
    valu_pkg::data_t s1_data;

    // move is data0 | 0
    assign opnd1 = ctrl.move ? '0 : data1;
    assign op    = ctrl.move ? valu_pkg::LOGIC_OR : ctrl.op;

    always_comb begin
        case (op)
            valu_pkg::LOGIC_AND: bitwise = opnd1 & data0;
            valu_pkg::LOGIC_OR:  bitwise = opnd1 | data0;
            valu_pkg::LOGIC_XOR: bitwise = opnd1 ^ data0;
            default:             bitwise = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= ctrl.en;
        end
    end

    always_ff @(posedge clk) begin
        s1_data <= bitwise;
    end

    // extra stage to line up with the add unit
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid <= s1_valid;
            result.data  <= s1_valid ? s1_data : '0;
        end
    end

endmodule

`default_nettype wire

//--- source/valu_add_min_max.sv
`timescale 1ns/1ns
`default_nettype none

module valu_add_min_max (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire valu_pkg::add_ctrl_t    ctrl,
    input  wire valu_pkg::data_t        data0,
    input  wire valu_pkg::data_t        data1,
    input  wire valu_pkg::sew_t         sew,
    output valu_pkg::unit_result_t      result
);

    localparam int NBYTES = valu_pkg::DATA_WIDTH / 8;

    valu_pkg::data_t     sum_w  [4];
    valu_pkg::data_t     diff_w [4];
    logic [NBYTES-1:0]   lt_w   [4];   // one flag per lane, lane i at bit i

    valu_pkg::add_ctrl_t s1_ctrl;
    valu_pkg::sew_t      s1_sew;
    valu_pkg::data_t     s1_sum;
    valu_pkg::data_t     s1_diff;
    valu_pkg::data_t     s1_data0;
    valu_pkg::data_t     s1_data1;
    logic [NBYTES-1:0]   s1_lt;

    logic [NBYTES-1:0]   byte_lt;
    valu_pkg::data_t     s2_data;

    // every lane width in parallel, picked by sew below
    for (genvar w = 0; w < 4; w++) begin : g_sew
        localparam int LW = 8 << w;
        localparam int NL = valu_pkg::DATA_WIDTH / LW;

        for (genvar l = 0; l < NL; l++) begin : g_lane
            logic [LW-1:0] a;   // vs2 lane
            logic [LW-1:0] b;

            assign a = data1[l*LW +: LW];
            assign b = data0[l*LW +: LW];

            assign sum_w[w][l*LW +: LW]  = a + b;
            assign diff_w[w][l*LW +: LW] = ctrl.rsub ? b - a : a - b;
            assign lt_w[w][l] = ctrl.signed_op ? ($signed(a) < $signed(b)) : (a < b);
        end

        if (NL < NBYTES) begin : g_lt_pad
            assign lt_w[w][NBYTES-1:NL] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_ctrl <= '0;
            s1_sew  <= valu_pkg::SEW_8;
        end else begin
            s1_ctrl <= ctrl;
            s1_sew  <= sew;
        end
    end

    always_ff @(posedge clk) begin
        s1_sum   <= sum_w[sew];
        s1_diff  <= diff_w[sew];
        s1_lt    <= lt_w[sew];
        s1_data0 <= data0;
        s1_data1 <= data1;
    end

    // spread lane flags over the bytes of each lane
    always_comb begin
        for (int b = 0; b < NBYTES; b++) begin
            byte_lt[b] = s1_lt[b >> s1_sew];
        end
    end

    always_comb begin
        if (s1_ctrl.minmax) begin
            for (int b = 0; b < NBYTES; b++) begin
                s2_data[b*8 +: 8] = (byte_lt[b] ^ s1_ctrl.max_sel) ? s1_data1[b*8 +: 8]
                                                                   : s1_data0[b*8 +: 8];
            end
        end else if (s1_ctrl.sub | s1_ctrl.rsub) begin
            s2_data = s1_diff;
        end else begin
            s2_data = s1_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid <= s1_ctrl.en;
            result.data  <= s1_ctrl.en ? s2_data : '0;  // zero when idle for the OR combine
        end
    end

endmodule

`default_nettype wire

//--- source/valu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module valu_decode (
    input  wire logic                   req_valid,
    input  wire valu_pkg::func_id_t     req_func_id,
    input  wire logic                   req_mask,
    output valu_pkg::add_ctrl_t         add_ctrl,
    output valu_pkg::logic_ctrl_t       logic_ctrl
);

    always_comb begin
        add_ctrl   = '0;
        logic_ctrl = '0;

        case (req_func_id)
            valu_pkg::FUNC_ADD: add_ctrl.en = 1'b1;
            valu_pkg::FUNC_SUB: begin
                add_ctrl.en  = 1'b1;
                add_ctrl.sub = 1'b1;
            end
            valu_pkg::FUNC_RSUB: begin
                add_ctrl.en   = 1'b1;
                add_ctrl.rsub = 1'b1;
            end
            valu_pkg::FUNC_MINU, valu_pkg::FUNC_MIN,
            valu_pkg::FUNC_MAXU, valu_pkg::FUNC_MAX: begin
                add_ctrl.en        = 1'b1;
                add_ctrl.minmax    = 1'b1;
                add_ctrl.max_sel   = req_func_id[1];
                add_ctrl.signed_op = req_func_id[0];
            end
            valu_pkg::FUNC_AND: begin
                logic_ctrl.en = 1'b1;
                logic_ctrl.op = valu_pkg::LOGIC_AND;
            end
            valu_pkg::FUNC_OR: begin
                logic_ctrl.en = 1'b1;
                logic_ctrl.op = valu_pkg::LOGIC_OR;
            end
            valu_pkg::FUNC_XOR: begin
                logic_ctrl.en = 1'b1;
                logic_ctrl.op = valu_pkg::LOGIC_XOR;
            end
            valu_pkg::FUNC_MOVE: begin
                // unmasked form would be a merge, not handled here
                if (req_mask) begin
                    logic_ctrl.en   = 1'b1;
                    logic_ctrl.move = 1'b1;
                    logic_ctrl.op   = valu_pkg::LOGIC_OR;
                end
            end
            default: ;
        endcase

        add_ctrl.en   = add_ctrl.en & req_valid;
        logic_ctrl.en = logic_ctrl.en & req_valid;
    end

endmodule

`default_nettype wire

//--- source/valu_pkg.sv
`default_nettype none

package valu_pkg;

    localparam int DATA_WIDTH = 64;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [31:0]             addr_t;
    typedef logic [7:0]              vl_t;
    typedef logic [DATA_WIDTH/8-1:0] be_t;
    typedef logic [7:0]              off_t;
    typedef logic [1:0]              sew_t;
    typedef logic [5:0]              func_id_t;

    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;
    localparam sew_t SEW_64 = 2'd3;

    localparam func_id_t FUNC_ADD  = 6'b000000;
    localparam func_id_t FUNC_SUB  = 6'b000010;
    localparam func_id_t FUNC_RSUB = 6'b000011;
    localparam func_id_t FUNC_MINU = 6'b000100;
    localparam func_id_t FUNC_MIN  = 6'b000101;
    localparam func_id_t FUNC_MAXU = 6'b000110;
    localparam func_id_t FUNC_MAX  = 6'b000111;
    localparam func_id_t FUNC_AND  = 6'b001001;
    localparam func_id_t FUNC_OR   = 6'b001010;
    localparam func_id_t FUNC_XOR  = 6'b001011;
    localparam func_id_t FUNC_MOVE = 6'b010111;

    // same as the low two bits of the logic function codes
    localparam logic [1:0] LOGIC_AND = 2'b01;
    localparam logic [1:0] LOGIC_OR  = 2'b10;
    localparam logic [1:0] LOGIC_XOR = 2'b11;

    typedef struct packed {
        logic  start_flag;
        logic  end_flag;
        vl_t   vl;
        sew_t  sew;
        off_t  off;
        addr_t addr;
        be_t   be;
    } sideband_t;

    typedef struct packed {
        logic en;
        logic sub;
        logic rsub;
        logic minmax;
        logic max_sel;
        logic signed_op;
    } add_ctrl_t;

    typedef struct packed {
        logic       en;
        logic [1:0] op;
        logic       move;
    } logic_ctrl_t;

    typedef struct packed {
        logic  valid;
        data_t data;
    } unit_result_t;

endpackage

`default_nettype wire
